/* busPkg.sv */
// Bus widths, transfer codes and request/response structs shared by every block on the memory bus
`default_nettype none

package busPkg;

  localparam int busAddrW = 32;
  localparam int busDataW = 32;
  localparam int busLanes = busDataW / 8;

  // Transfer size as carried to the memory slave
  typedef enum logic [1:0] {
    sizeByte = 2'b00,
    sizeHalf = 2'b01,
    sizeWord = 2'b10
  } busSize_t;

  // Requesters that can own the bus
  typedef enum logic [1:0] {
    masterNone  = 2'b00,
    masterFetch = 2'b01,
    masterData  = 2'b10,
    masterWalk  = 2'b11
  } master_t;

  // Word-read request of the fetch and table-walk ports
  typedef struct packed {
    logic                valid;
    logic [busAddrW-1:0] addr;
  } readReq_t;

  // Data-port request, byte mask still unresolved
  typedef struct packed {
    logic                valid;
    logic                write;
    logic [busLanes-1:0] mask;
    logic [busAddrW-1:0] addr;
    logic [busDataW-1:0] wdata;
  } dataReq_t;

  // Request as seen by the memory slave
  typedef struct packed {
    logic                valid;
    logic                write;
    busSize_t            size;
    logic [busAddrW-1:0] addr;
    logic [busDataW-1:0] wdata;
  } busReq_t;

  typedef struct packed {
    logic                ready;
    logic [busDataW-1:0] rdata;
  } busRsp_t;

endpackage

`default_nettype wire

/* memPkg.sv */
// Sizing and timing constants of the memory slave, imported by busMemory
`default_nettype none

package memPkg;

  // Word array depth and the index bits that address it
  localparam int memDepthWords = 256;
  localparam int memIndexW     = 8;

  // Cycles spent waiting before ready is raised
  localparam int memWaitStates = 2;

  // Width of the wait-state counter
  localparam int memCountW     = $clog2(memWaitStates + 1);

endpackage

`default_nettype wire

/* byteLaneFormat.sv */
// Data-port lane formatter, turns byte masks into sized bus transfers and aligns read data
`timescale 1ns/1ps
`default_nettype none

module byteLaneFormat import busPkg::*; (
  input  dataReq_t dataReq,
  input  busRsp_t  memRsp,
  output busReq_t  busReq,
  output busRsp_t  dataRsp
);

  busSize_t            size;
  logic [1:0]          offset;
  logic [busDataW-1:0] readShifted;

  // Mask decode, anything irregular is treated as a full word
  always_comb
  begin
    size   = sizeWord;
    offset = 2'b00;
    case (dataReq.mask)
      4'b0001: begin size = sizeByte; offset = 2'd0; end
      4'b0010: begin size = sizeByte; offset = 2'd1; end
      4'b0100: begin size = sizeByte; offset = 2'd2; end
      4'b1000: begin size = sizeByte; offset = 2'd3; end
      4'b0011: begin size = sizeHalf; offset = 2'd0; end
      4'b1100: begin size = sizeHalf; offset = 2'd2; end
      default: begin size = sizeWord; offset = 2'd0; end
    endcase
  end

  // Low bytes of write data moved up into their lanes
  always_comb
  begin
    busReq.valid = dataReq.valid;
    busReq.write = dataReq.write;
    busReq.size  = size;
    busReq.addr  = {dataReq.addr[busAddrW-1:2], offset};
    busReq.wdata = dataReq.wdata << {offset, 3'b000};
  end

  // Selected lanes brought down to bit 0, upper bits zeroed
  always_comb
  begin
    readShifted   = memRsp.rdata >> {offset, 3'b000};
    dataRsp.ready = memRsp.ready;
    case (size)
      sizeByte: dataRsp.rdata = {{(busDataW - 8){1'b0}}, readShifted[7:0]};
      sizeHalf: dataRsp.rdata = {{(busDataW - 16){1'b0}}, readShifted[15:0]};
      default:  dataRsp.rdata = readShifted;
    endcase
  end

endmodule

`default_nettype wire

/* busArbiter.sv */
// Fixed-priority owner of the shared bus, walk over data over fetch, one transfer at a time
`timescale 1ns/1ps
`default_nettype none

module busArbiter import busPkg::*; (
  input  logic     clk,
  input  logic     arstN,
  input  readReq_t fetchReq,
  input  readReq_t walkReq,
  input  busReq_t  dataBusReq,
  input  busRsp_t  memRsp,
  output busReq_t  memReq,
  output busRsp_t  fetchRsp,
  output busRsp_t  walkRsp,
  output busRsp_t  dataBusRsp
);

  master_t grant;
  master_t grantNext;
  busReq_t fetchBusReq;
  busReq_t walkBusReq;

  // Fetch and walk only ever read whole words
  always_comb
  begin
    fetchBusReq.valid = fetchReq.valid;
    fetchBusReq.write = 1'b0;
    fetchBusReq.size  = sizeWord;
    fetchBusReq.addr  = fetchReq.addr;
    fetchBusReq.wdata = '0;

    walkBusReq.valid  = walkReq.valid;
    walkBusReq.write  = 1'b0;
    walkBusReq.size   = sizeWord;
    walkBusReq.addr   = walkReq.addr;
    walkBusReq.wdata  = '0;
  end

  // Pick a new owner only from idle; drop ownership on ready
  always_comb
  begin
    grantNext = grant;
    if (grant == masterNone)
    begin
      if (walkReq.valid)
        grantNext = masterWalk;
      else if (dataBusReq.valid)
        grantNext = masterData;
      else if (fetchReq.valid)
        grantNext = masterFetch;
    end
    else if (memRsp.ready)
    begin
      grantNext = masterNone;
    end
  end

  always_ff @(posedge clk or negedge arstN)
  begin
    if (!arstN)
      grant <= masterNone;
    else
      grant <= grantNext;
  end

  // Owner's request goes to the memory, nothing while idle
  always_comb
  begin
    case (grant)
      masterFetch: memReq = fetchBusReq;
      masterData:  memReq = dataBusReq;
      masterWalk:  memReq = walkBusReq;
      default:     memReq = '0;
    endcase
  end

  // Read data fans out to all ports, ready only to the owner
  always_comb
  begin
    fetchRsp.rdata   = memRsp.rdata;
    walkRsp.rdata    = memRsp.rdata;
    dataBusRsp.rdata = memRsp.rdata;

    fetchRsp.ready   = memRsp.ready && (grant == masterFetch);
    walkRsp.ready    = memRsp.ready && (grant == masterWalk);
    dataBusRsp.ready = memRsp.ready && (grant == masterData);
  end

endmodule

`default_nettype wire

/* busMemory.sv */
// Word-organised memory slave with fixed wait states and byte-lane writes, sits behind the arbiter
`timescale 1ns/1ps
`default_nettype none

module busMemory import busPkg::*, memPkg::*; (
  input  logic    clk,
  input  logic    arstN,
  input  busReq_t memReq,
  output busRsp_t memRsp
);

  logic [busDataW-1:0]  memArray [memDepthWords];
  logic [memCountW-1:0] waitCnt;
  logic                 readyQ;
  logic [busDataW-1:0]  rdataQ;
  logic [memIndexW-1:0] wordIdx;
  logic [busLanes-1:0]  laneEn;
  logic                 lastWait;

  // Word index sits just above the byte offset
  assign wordIdx  = memReq.addr[memIndexW+1:2];

  // Final waiting cycle, ready follows at the next edge
  assign lastWait = memReq.valid && !readyQ && (waitCnt == memCountW'(memWaitStates));

  // Lanes touched by a write of this size and offset
  always_comb
  begin
    case (memReq.size)
      sizeByte: laneEn = 4'b0001 << memReq.addr[1:0];
      sizeHalf: laneEn = memReq.addr[1] ? 4'b1100 : 4'b0011;
      default:  laneEn = 4'b1111;
    endcase
  end

  // Wait-state counter and the single-cycle ready
  always_ff @(posedge clk or negedge arstN)
  begin
    if (!arstN)
    begin
      waitCnt <= '0;
      readyQ  <= 1'b0;
    end
    else if (readyQ)
    begin
      waitCnt <= '0;
      readyQ  <= 1'b0;
    end
    else if (memReq.valid)
    begin
      if (lastWait)
        readyQ <= 1'b1;
      else
        waitCnt <= waitCnt + 1'b1;
    end
  end

  // Read word captured so it lines up with ready
  always_ff @(posedge clk)
  begin
    if (lastWait)
      rdataQ <= memArray[wordIdx];
  end

  // Writes land at the edge that closes the ready cycle
  always_ff @(posedge clk)
  begin
    if (readyQ && memReq.write)
    begin
      for (int b = 0; b < busLanes; b++)
      begin
        if (laneEn[b])
          memArray[wordIdx][8*b +: 8] <= memReq.wdata[8*b +: 8];
      end
    end
  end

  always_comb
  begin
    memRsp.ready = readyQ;
    memRsp.rdata = rdataQ;
  end

endmodule

`default_nettype wire

/* memBusTop.sv */
// Memory bus subsystem top, joins the data-lane formatter, arbiter and memory behind three ports
`timescale 1ns/1ps
`default_nettype none

module memBusTop import busPkg::*; (
  input  logic     clk,
  input  logic     arstN,
  input  readReq_t fetchReq,
  input  readReq_t walkReq,
  input  dataReq_t dataReq,
  output busRsp_t  fetchRsp,
  output busRsp_t  walkRsp,
  output busRsp_t  dataRsp
);

  // Data port after mask resolution
  busReq_t dataBusReq;
  busRsp_t dataBusRsp;

  // Arbiter to memory
  busReq_t memReq;
  busRsp_t memRsp;

  byteLaneFormat laneFmt (
    .dataReq (dataReq   ),
    .memRsp  (dataBusRsp),
    .busReq  (dataBusReq),
    .dataRsp (dataRsp   )
  );

  busArbiter busArb (
    .clk        (clk       ),
    .arstN      (arstN     ),
    .fetchReq   (fetchReq  ),
    .walkReq    (walkReq   ),
    .dataBusReq (dataBusReq),
    .memRsp     (memRsp    ),
    .memReq     (memReq    ),
    .fetchRsp   (fetchRsp  ),
    .walkRsp    (walkRsp   ),
    .dataBusRsp (dataBusRsp)
  );

  // Single slave answering whoever holds the grant
  busMemory busMem (
    .clk    (clk   ),
    .arstN  (arstN ),
    .memReq (memReq),
    .memRsp (memRsp)
  );

endmodule

`default_nettype wire

/* memBus_properties.sv */
// Grant and handshake assertions bound into every busArbiter instance
`timescale 1ns/1ps
`default_nettype none

module memBusProperties import busPkg::*; (
  input logic     clk,
  input logic     arstN,
  input master_t  grant,
  input readReq_t fetchReq,
  input readReq_t walkReq,
  input busReq_t  dataBusReq,
  input busRsp_t  memRsp,
  input busRsp_t  fetchRsp,
  input busRsp_t  walkRsp,
  input busRsp_t  dataBusRsp
);

  // Exactly one owner code or none
  grantKnown: assert property (@(posedge clk) disable iff (!arstN)
    !$isunknown(grant))
    else $error("grant register is unknown");

  // Ready reaches only the owner while its request is up
  readyToOwner: assert property (@(posedge clk) disable iff (!arstN)
    (!fetchRsp.ready || (grant == masterFetch && fetchReq.valid)) &&
    (!walkRsp.ready || (grant == masterWalk && walkReq.valid)) &&
    (!dataBusRsp.ready || (grant == masterData && dataBusReq.valid)))
    else $error("ready routed to a port that does not own the bus");

  idleNoReady: assert property (@(posedge clk) disable iff (!arstN)
    (grant == masterNone) |-> !memRsp.ready)
    else $error("memory ready while no grant is held");

  // Owner keeps its request steady until its ready
  fetchHold: assert property (@(posedge clk) disable iff (!arstN)
    (grant == masterFetch && !memRsp.ready) |=> $stable(fetchReq))
    else $error("fetch request changed before ready");

  walkHold: assert property (@(posedge clk) disable iff (!arstN)
    (grant == masterWalk && !memRsp.ready) |=> $stable(walkReq))
    else $error("walk request changed before ready");

  dataHold: assert property (@(posedge clk) disable iff (!arstN)
    (grant == masterData && !memRsp.ready) |=> $stable(dataBusReq))
    else $error("data request changed before ready");

endmodule

bind busArbiter memBusProperties arbProps (
  .clk        (clk       ),
  .arstN      (arstN     ),
  .grant      (grant     ),
  .fetchReq   (fetchReq  ),
  .walkReq    (walkReq   ),
  .dataBusReq (dataBusReq),
  .memRsp     (memRsp    ),
  .fetchRsp   (fetchRsp  ),
  .walkRsp    (walkRsp   ),
  .dataBusRsp (dataBusRsp)
);

`default_nettype wire

/* memBusTb.sv */
// Random three-port testbench that checks memory bus data, latency and priority against a model
`timescale 1ns/1ps
`default_nettype none

module memBusTb import busPkg::*; ();

  localparam int clkPeriodNs = 40;
  localparam int numTrans    = 300;
  localparam int portFetch   = 0;
  localparam int portData    = 1;
  localparam int portWalk    = 2;

  logic     clk;
  logic     arstN;
  readReq_t fetchReq;
  readReq_t walkReq;
  dataReq_t dataReq;
  busRsp_t  fetchRsp;
  busRsp_t  walkRsp;
  busRsp_t  dataRsp;

  // Request each port holds until its ready
  readReq_t fetchHeld;
  readReq_t walkHeld;
  dataReq_t dataHeld;

  logic [15:0] lfsrState;
  logic [7:0]  modelMem [128];
  logic        modelWritten [128];
  logic        pending [3];
  int          issueCycle [3];
  int          lastReadyCycle;
  int          cycle;
  int          issued;
  int          completed;

  memBusTop dut0 (
    .clk      (clk     ),
    .arstN    (arstN   ),
    .fetchReq (fetchReq),
    .walkReq  (walkReq ),
    .dataReq  (dataReq ),
    .fetchRsp (fetchRsp),
    .walkRsp  (walkRsp ),
    .dataRsp  (dataRsp )
  );

  initial clk = 1'b0;
  always #(clkPeriodNs / 2) clk = ~clk;

  initial
  begin
    #(numTrans * 3 * 8 * clkPeriodNs);
    failRun("watchdog expired before all bus transactions completed");
  end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsrNext(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // One LFSR step per bit handed out
  function automatic logic [31:0] randBits(input int n);
    logic [31:0] r;
    int          i;
    r = '0;
    for (i = 0; i < n; i++)
    begin
      lfsrState = lfsrNext(lfsrState);
      r = {r[30:0], lfsrState[0]};
    end
    return r;
  endfunction

  // Lane offset and byte count of a mask with irregular masks counted as a word
  function automatic logic [4:0] laneSpan(input logic [3:0] mask);
    case (mask)
      4'b0001: return {2'd0, 3'd1};
      4'b0010: return {2'd1, 3'd1};
      4'b0100: return {2'd2, 3'd1};
      4'b1000: return {2'd3, 3'd1};
      4'b0011: return {2'd0, 3'd2};
      4'b1100: return {2'd2, 3'd2};
      default: return {2'd0, 3'd4};
    endcase
  endfunction

  task automatic failRun(input string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic checkEqual(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    if (actual !== expected)
      failRun($sformatf("mismatch at %0d ns: %s is %h, expected %h",
                        $time, name, actual, expected));
  endtask

  task automatic handleReady(input int p, input logic [31:0] rdata);
    int          earliest;
    int          grantEdge;
    int          owner;
    int          base;
    int          bytes;
    int          b;
    logic [4:0]  span;
    logic [31:0] expWord;
    logic [31:0] cmpMask;
    if (!pending[p])
      failRun($sformatf("ready on port %0d at %0d ns with no request pending", p, $time));
    // Next grant edge comes one edge after a request and two after the previous ready
    earliest = cycle;
    for (b = 0; b < 3; b++)
    begin
      if (pending[b] && issueCycle[b] + 1 < earliest)
        earliest = issueCycle[b] + 1;
    end
    grantEdge = (earliest > lastReadyCycle + 2) ? earliest : lastReadyCycle + 2;
    if (pending[portWalk] && issueCycle[portWalk] + 1 <= grantEdge)
      owner = portWalk;
    else if (pending[portData] && issueCycle[portData] + 1 <= grantEdge)
      owner = portData;
    else
      owner = portFetch;
    checkEqual("grant owner", p, owner);
    // Grant edge, two wait states, then ready
    checkEqual("ready cycle", cycle, grantEdge + 3);
    expWord = '0;
    cmpMask = '0;
    if (p == portData)
    begin
      span  = laneSpan(dataHeld.mask);
      base  = int'(dataHeld.addr[6:2]) * 4 + int'(span[4:3]);
      bytes = int'(span[2:0]);
      for (b = 0; b < 4; b++)
      begin
        // Lanes beyond the access width read back as zero
        if (b >= bytes)
          cmpMask[8*b +: 8] = 8'hff;
        else if (dataHeld.write)
        begin
          modelMem[base + b]     = dataHeld.wdata[8*b +: 8];
          modelWritten[base + b] = 1'b1;
        end
        else if (modelWritten[base + b])
        begin
          cmpMask[8*b +: 8] = 8'hff;
          expWord[8*b +: 8] = modelMem[base + b];
        end
      end
      if (!dataHeld.write)
        checkEqual("dataRsp.rdata", rdata & cmpMask, expWord);
      dataHeld.valid = 1'b0;
    end
    else
    begin
      if (p == portWalk)
        base = int'(walkHeld.addr[6:2]) * 4;
      else
        base = int'(fetchHeld.addr[6:2]) * 4;
      for (b = 0; b < 4; b++)
      begin
        if (modelWritten[base + b])
        begin
          cmpMask[8*b +: 8] = 8'hff;
          expWord[8*b +: 8] = modelMem[base + b];
        end
      end
      if (p == portWalk)
      begin
        checkEqual("walkRsp.rdata", rdata & cmpMask, expWord);
        walkHeld.valid = 1'b0;
      end
      else
      begin
        checkEqual("fetchRsp.rdata", rdata & cmpMask, expWord);
        fetchHeld.valid = 1'b0;
      end
    end
    pending[p]     = 1'b0;
    lastReadyCycle = cycle;
    completed++;
  endtask

  // Idle ports may start a new request that shows from the next edge
  task automatic issueRequests();
    logic [2:0] sel;
    if (!pending[portFetch] && issued < numTrans && randBits(1) == 1)
    begin
      fetchHeld.valid       = 1'b1;
      fetchHeld.addr        = randBits(7);
      pending[portFetch]    = 1'b1;
      issueCycle[portFetch] = cycle + 1;
      issued++;
    end
    if (!pending[portWalk] && issued < numTrans && randBits(1) == 1)
    begin
      walkHeld.valid       = 1'b1;
      walkHeld.addr        = randBits(7);
      pending[portWalk]    = 1'b1;
      issueCycle[portWalk] = cycle + 1;
      issued++;
    end
    if (!pending[portData] && issued < numTrans && randBits(1) == 1)
    begin
      sel            = 3'(randBits(3));
      dataHeld.valid = 1'b1;
      dataHeld.write = 1'(randBits(1));
      case (sel)
        3'd4:    dataHeld.mask = 4'b0011;
        3'd5:    dataHeld.mask = 4'b1100;
        3'd6:    dataHeld.mask = 4'b1111;
        3'd7:    dataHeld.mask = 4'(randBits(4));
        default: dataHeld.mask = 4'b0001 << sel[1:0];
      endcase
      dataHeld.addr        = randBits(7);
      dataHeld.wdata       = randBits(32);
      pending[portData]    = 1'b1;
      issueCycle[portData] = cycle + 1;
      issued++;
    end
  endtask

  // Drive on the rising edge and sample responses on the falling edge
  task automatic stepCycle();
    @(posedge clk);
    cycle++;
    fetchReq <= fetchHeld;
    walkReq  <= walkHeld;
    dataReq  <= dataHeld;
    @(negedge clk);
    if ($isunknown({fetchRsp.ready, walkRsp.ready, dataRsp.ready}))
      failRun("a ready output is unknown after reset");
    if (int'(fetchRsp.ready) + int'(walkRsp.ready) + int'(dataRsp.ready) > 1)
      failRun("more than one port saw ready in the same cycle");
    if (fetchRsp.ready)
      handleReady(portFetch, fetchRsp.rdata);
    if (walkRsp.ready)
      handleReady(portWalk, walkRsp.rdata);
    if (dataRsp.ready)
      handleReady(portData, dataRsp.rdata);
  endtask

  initial
  begin
    lfsrState      = 16'd39946;
    fetchReq       = '0;
    walkReq        = '0;
    dataReq        = '0;
    fetchHeld      = '0;
    walkHeld       = '0;
    dataHeld       = '0;
    arstN          = 1'b0;
    cycle          = 0;
    issued         = 0;
    completed      = 0;
    lastReadyCycle = -100;
    foreach (modelWritten[i])
      modelWritten[i] = 1'b0;
    foreach (pending[i])
      pending[i] = 1'b0;
    foreach (issueCycle[i])
      issueCycle[i] = 0;
    repeat (4) @(posedge clk);
    arstN <= 1'b1;
    // No ready may appear before the first request
    repeat (3) stepCycle();
    while (completed < numTrans)
    begin
      issueRequests();
      stepCycle();
    end
    repeat (4) stepCycle();
    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire

/* memBus.f */
busPkg.sv
memPkg.sv
byteLaneFormat.sv
busArbiter.sv
busMemory.sv
memBusTop.sv
memBus_properties.sv
memBusTb.sv
